//--- include/sdram_consts.svh
`ifndef SDRAM_CONSTS_SVH
`define SDRAM_CONSTS_SVH

// --------------------
// command codes
// --------------------
// bit order cke, cs_n, ras_n, cas_n, we_n
`define SDRAM_CMD_NOP    5'b10111
`define SDRAM_CMD_PREC   5'b10010   // precharge
`define SDRAM_CMD_AREF   5'b10001   // auto refresh
`define SDRAM_CMD_MRS    5'b10000   // mode register set

// --------------------
// timing counts
// --------------------
// 100 MHz system clock, 10 ns per cycle
`define SDRAM_INIT_WAIT    20_000   // 200 us power-up wait
`define SDRAM_AREF_PERIOD  1_200    // 12 us refresh interval

// --------------------
// address words
// --------------------
// a10 high selects all banks on precharge
`define SDRAM_ADDR_A10   12'h400

// burst length 4, sequential, cas latency 3
// a9 low so writes burst as well
`define SDRAM_MODE_WORD  12'h032

`endif

//--- hdl/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

	// --------------------
	// bus types
	// --------------------
	// {cke, cs_n, ras_n, cas_n, we_n}
	typedef logic [4:0] sdram_cmd_t;

	// row / column address, a10 doubles as all-bank flag
	typedef logic [11:0] sdram_addr_t;

	typedef logic [1:0] sdram_ba_t;   // 4 banks

	// --------------------
	// arbiter states
	// --------------------
	// who owns the command bus
	typedef enum logic [1:0] {
		ARB_INIT = 2'd0,   // power-up sequence
		ARB_IDLE = 2'd1,   // bus free, nop
		ARB_AREF = 2'd2    // periodic refresh
	} arb_state_t;

	// one spare encoding, never entered
	// next-state logic falls back to idle

endpackage

`default_nettype wire

//--- hdl/sdram_init.sv
`default_nettype none

`include "sdram_consts.svh"

module sdram_init
	import sdram_pkg::*;
(
	input  wire         S_CLK,
	input  wire         RST_N,
	output sdram_cmd_t  init_cmd,    // to arbiter
	output sdram_addr_t init_addr,
	output logic        init_done    // sticky once mode reg loaded
);

	// --------------------
	// power-up wait
	// --------------------
	logic [14:0] wait_cnt;     // 20000 fits in 15 bits
	logic        wait_done;
	logic [4:0]  step_cnt;     // sequence position

	assign wait_done = (wait_cnt == `SDRAM_INIT_WAIT);

	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			wait_cnt <= '0;
		end else if (!wait_done) begin
			wait_cnt <= wait_cnt + 1'b1;   // saturates at the wait count
		end
	end

	// --------------------
	// command sequence
	// --------------------
	// step 0 prec all, 2 and 9 aref, 16 mrs, 18 done
	// gaps between steps cover trp and trc
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			step_cnt  <= '0;
			init_cmd  <= `SDRAM_CMD_NOP;
			init_addr <= '0;
			init_done <= 1'b0;
		end else if (wait_done && !init_done) begin
			case (step_cnt)
				5'd0: begin
					init_cmd  <= `SDRAM_CMD_PREC;
					init_addr <= `SDRAM_ADDR_A10;   // all banks
				end
				5'd2, 5'd9: begin
					init_cmd  <= `SDRAM_CMD_AREF;
					init_addr <= '0;
				end
				5'd16: begin
					init_cmd  <= `SDRAM_CMD_MRS;
					init_addr <= `SDRAM_MODE_WORD;  // cl3, bl4
				end
				5'd18: begin
					init_cmd  <= `SDRAM_CMD_NOP;
					init_addr <= '0;
					init_done <= 1'b1;   // tmrd met, hand over
				end
				default: begin
					init_cmd  <= `SDRAM_CMD_NOP;
					init_addr <= '0;
				end
			endcase
			step_cnt <= step_cnt + 1'b1;
		end else begin
			// waiting, or finished for good
			init_cmd  <= `SDRAM_CMD_NOP;
			init_addr <= '0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/sdram_aref.sv
`default_nettype none

`include "sdram_consts.svh"

module sdram_aref
	import sdram_pkg::*;
(
	input  wire         S_CLK,
	input  wire         RST_N,
	input  wire         init_done,   // interval counter runs only after init
	input  wire         aref_en,     // grant from arbiter
	output logic        aref_req,
	output logic        aref_ack,
	output sdram_cmd_t  aref_cmd,
	output sdram_addr_t aref_addr
);

	logic [10:0] aref_cnt;    // interval counter, 1200 max
	logic        aref_tick;   // one cycle per interval
	logic [4:0]  step_cnt;

	// --------------------
	// refresh interval
	// --------------------
	// wraps after hitting the period, so ticks are period+1 apart
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			aref_cnt <= '0;
		end else if (init_done) begin
			if (aref_cnt == `SDRAM_AREF_PERIOD)
				aref_cnt <= '0;
			else
				aref_cnt <= aref_cnt + 1'b1;
		end
	end

	assign aref_tick = (aref_cnt == `SDRAM_AREF_PERIOD);

	// request held until the grant shows up
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N)
			aref_req <= 1'b0;
		else if (aref_tick)
			aref_req <= 1'b1;
		else if (aref_en)
			aref_req <= 1'b0;
	end

	// --------------------
	// refresh sequence
	// --------------------
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			step_cnt  <= '0;
			aref_cmd  <= `SDRAM_CMD_NOP;
			aref_addr <= '0;
			aref_ack  <= 1'b0;
		end else if (aref_en) begin
			case (step_cnt)
				5'd0: begin
					aref_cmd  <= `SDRAM_CMD_PREC;
					aref_addr <= `SDRAM_ADDR_A10;   // close every bank first
				end
				5'd2, 5'd9: begin
					aref_cmd  <= `SDRAM_CMD_AREF;   // trp, then trc apart
					aref_addr <= '0;
				end
				5'd16: begin
					aref_cmd <= `SDRAM_CMD_NOP;
					aref_ack <= 1'b1;   // done, arbiter drops en
				end
				default: begin
					aref_cmd  <= `SDRAM_CMD_NOP;
					aref_addr <= '0;
				end
			endcase
			step_cnt <= step_cnt + 1'b1;
		end else begin
			// not granted, park
			step_cnt  <= '0;
			aref_cmd  <= `SDRAM_CMD_NOP;
			aref_addr <= '0;
			aref_ack  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/sdram_arbiter.sv
`default_nettype none

`include "sdram_consts.svh"

module sdram_arbiter
	import sdram_pkg::*;
(
	input  wire         S_CLK,
	input  wire         RST_N,
	input  wire         init_done,
	input  sdram_cmd_t  init_cmd,
	input  sdram_addr_t init_addr,
	input  wire         aref_req,
	input  wire         aref_ack,
	input  sdram_cmd_t  aref_cmd,
	input  sdram_addr_t aref_addr,
	output logic        aref_en,
	output logic        sdram_cke,
	output logic        sdram_cs_n,
	output logic        sdram_ras_n,
	output logic        sdram_cas_n,
	output logic        sdram_we_n,
	output sdram_addr_t sdram_addr,
	output sdram_ba_t   sdram_ba
);

	arb_state_t  state, state_nxt;
	sdram_cmd_t  sel_cmd, cmd_q;     // selected source, pin register
	sdram_addr_t sel_addr, addr_q;

	// --------------------
	// bus ownership fsm
	// --------------------
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N)
			state <= ARB_INIT;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		sel_cmd   = `SDRAM_CMD_NOP;
		sel_addr  = '0;
		case (state)
			ARB_INIT: begin
				sel_cmd  = init_cmd;    // initializer owns the bus
				sel_addr = init_addr;
				if (init_done) state_nxt = ARB_IDLE;
			end
			ARB_IDLE: if (aref_req) state_nxt = ARB_AREF;
			ARB_AREF: begin
				sel_cmd  = aref_cmd;
				sel_addr = aref_addr;
				if (aref_ack) state_nxt = ARB_IDLE;
			end
			default: state_nxt = ARB_IDLE;
		endcase
	end

	assign aref_en = (state == ARB_AREF);   // grant level

	// --------------------
	// pin register
	// --------------------
	always_ff @(posedge S_CLK or negedge RST_N) begin
		if (!RST_N) begin
			cmd_q  <= `SDRAM_CMD_NOP;   // nop, cke high
			addr_q <= '0;
		end else begin
			cmd_q  <= sel_cmd;
			addr_q <= sel_addr;
		end
	end

	assign {sdram_cke, sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd_q;
	assign sdram_addr = addr_q;
	assign sdram_ba   = '0;   // all-bank commands only

endmodule

`default_nettype wire

//--- hdl/sdram_ctrl_top.sv
`default_nettype none

module sdram_ctrl_top
	import sdram_pkg::*;
(
	input  wire         S_CLK,
	input  wire         RST_N,
	output logic        init_done,
	output logic        sdram_cke,
	output logic        sdram_cs_n,
	output logic        sdram_ras_n,
	output logic        sdram_cas_n,
	output logic        sdram_we_n,
	output sdram_addr_t sdram_addr,
	output sdram_ba_t   sdram_ba
);

	// --------------------
	// sequencer to arbiter
	// --------------------
	sdram_cmd_t  init_cmd, aref_cmd;
	sdram_addr_t init_addr, aref_addr;
	logic        aref_req, aref_en, aref_ack;   // refresh handshake

	sdram_init u_init (
		.S_CLK     (S_CLK),
		.RST_N     (RST_N),
		.init_cmd  (init_cmd),
		.init_addr (init_addr),
		.init_done (init_done)
	);

	sdram_aref u_aref (
		.S_CLK     (S_CLK),
		.RST_N     (RST_N),
		.init_done (init_done),
		.aref_en   (aref_en),
		.aref_req  (aref_req),
		.aref_ack  (aref_ack),
		.aref_cmd  (aref_cmd),
		.aref_addr (aref_addr)
	);

	// picks the owner and drives the pins
	sdram_arbiter u_arbiter (
		.S_CLK       (S_CLK),
		.RST_N       (RST_N),
		.init_done   (init_done),
		.init_cmd    (init_cmd),
		.init_addr   (init_addr),
		.aref_req    (aref_req),
		.aref_ack    (aref_ack),
		.aref_cmd    (aref_cmd),
		.aref_addr   (aref_addr),
		.aref_en     (aref_en),
		.sdram_cke   (sdram_cke),
		.sdram_cs_n  (sdram_cs_n),
		.sdram_ras_n (sdram_ras_n),
		.sdram_cas_n (sdram_cas_n),
		.sdram_we_n  (sdram_we_n),
		.sdram_addr  (sdram_addr),
		.sdram_ba    (sdram_ba)
	);

endmodule

`default_nettype wire

//--- bench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
	output logic S_CLK,
	output logic RST_N
);

	initial begin
		S_CLK = 1'b0;
		forever #10 S_CLK = ~S_CLK;   // period 20
	end

	// low for three rising edges, released on a falling edge
	initial begin
		RST_N = 1'b0;
		repeat (3) @(posedge S_CLK);
		@(negedge S_CLK);
		RST_N = 1'b1;
	end

endmodule

`default_nettype wire

//--- bench/tb_sdram_ctrl.sv
`default_nettype none

`include "sdram_consts.svh"

module tb_sdram_ctrl
	import sdram_pkg::*;
();

	localparam int NUM_ENTRIES = 13;   // 4 init + 3 bursts of 3
	localparam int TAIL_CYCLES = 20;   // rest of the last burst
	localparam int WATCHDOG_CYCLES = `SDRAM_INIT_WAIT + 4 * (`SDRAM_AREF_PERIOD + 1) + 200;

	logic        S_CLK, RST_N;
	logic        init_done;
	logic        sdram_cke, sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n;
	sdram_addr_t sdram_addr;
	sdram_ba_t   sdram_ba;
	sdram_cmd_t  pins;   // pin command, same bit order as the codes

	// --------------------
	// expected table
	// --------------------
	sdram_cmd_t  tbl_cmd  [NUM_ENTRIES];
	sdram_addr_t tbl_addr [NUM_ENTRIES];
	int          tbl_gap  [NUM_ENTRIES];   // cycles since last command, 0 = any
	int          tbl_pgap [NUM_ENTRIES];   // cycles since last prec, 0 = any
	logic        tbl_done [NUM_ENTRIES];   // init_done level at the command

	int   cyc;             // sample count
	int   last_cyc;
	int   last_prec_cyc;
	int   mrs_cyc;
	logic done_seen;
	int   fail_cnt;

	tb_clk_gen u_clk_gen (
		.S_CLK (S_CLK),
		.RST_N (RST_N)
	);

	sdram_ctrl_top u_dut (
		.S_CLK       (S_CLK),
		.RST_N       (RST_N),
		.init_done   (init_done),
		.sdram_cke   (sdram_cke),
		.sdram_cs_n  (sdram_cs_n),
		.sdram_ras_n (sdram_ras_n),
		.sdram_cas_n (sdram_cas_n),
		.sdram_we_n  (sdram_we_n),
		.sdram_addr  (sdram_addr),
		.sdram_ba    (sdram_ba)
	);

	assign pins = {sdram_cke, sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n};

	task automatic report_fail(input string what);
		fail_cnt++;
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic mismatch(input string sig, input int got, input int expected);
		report_fail($sformatf("mismatch at %0t: %s got 0x%0h expected 0x%0h",
			$time, sig, got, expected));
	endtask

	task automatic set_entry(input int idx, input sdram_cmd_t cmd, input sdram_addr_t addr,
		input int gap, input int pgap, input logic done);
		tbl_cmd[idx]  = cmd;
		tbl_addr[idx] = addr;
		tbl_gap[idx]  = gap;
		tbl_pgap[idx] = pgap;
		tbl_done[idx] = done;
	endtask

	task automatic load_table();
		int base;
		// power-up list, trp then trc then trc
		set_entry(0, `SDRAM_CMD_PREC, `SDRAM_ADDR_A10, 0, 0, 1'b0);
		set_entry(1, `SDRAM_CMD_AREF, '0, 2, 0, 1'b0);
		set_entry(2, `SDRAM_CMD_AREF, '0, 7, 0, 1'b0);
		set_entry(3, `SDRAM_CMD_MRS, `SDRAM_MODE_WORD, 7, 0, 1'b0);
		for (int b = 0; b < 3; b++) begin
			base = 4 + 3 * b;
			// first burst has no earlier refresh prec
			set_entry(base, `SDRAM_CMD_PREC, `SDRAM_ADDR_A10, 0,
				(b == 0) ? 0 : `SDRAM_AREF_PERIOD + 1, 1'b1);
			set_entry(base + 1, `SDRAM_CMD_AREF, '0, 2, 0, 1'b1);
			set_entry(base + 2, `SDRAM_CMD_AREF, '0, 7, 0, 1'b1);
		end
	endtask

	// --------------------
	// pin monitor
	// --------------------
	// one cycle, sampled on the falling edge where pins are settled
	task automatic sample_cycle();
		@(negedge S_CLK);
		cyc++;
		assert (sdram_ba == '0) else mismatch("sdram_ba", int'(sdram_ba), 0);
		assert (sdram_cke == 1'b1) else mismatch("sdram_cke", int'(sdram_cke), 1);
		if (done_seen) begin
			assert (init_done == 1'b1) else mismatch("init_done", int'(init_done), 1);   // sticky
		end else if (init_done) begin
			done_seen = 1'b1;
			assert (mrs_cyc >= 0 && cyc == mrs_cyc + 1) else
				report_fail("init_done rose without a mode register set one cycle before");
		end
	endtask

	task automatic check_entry(input int idx);
		int gap;
		gap = cyc - last_cyc;
		assert (pins == tbl_cmd[idx]) else mismatch("command", int'(pins), int'(tbl_cmd[idx]));
		assert (sdram_addr == tbl_addr[idx]) else
			mismatch("sdram_addr", int'(sdram_addr), int'(tbl_addr[idx]));
		if (tbl_gap[idx] != 0) begin
			assert (gap == tbl_gap[idx]) else mismatch("command gap", gap, tbl_gap[idx]);
		end
		if (tbl_cmd[idx] == `SDRAM_CMD_PREC) begin
			if (tbl_pgap[idx] != 0) begin
				assert (cyc - last_prec_cyc == tbl_pgap[idx]) else
					mismatch("refresh interval", cyc - last_prec_cyc, tbl_pgap[idx]);
			end
			last_prec_cyc = cyc;
		end
		assert (init_done == tbl_done[idx]) else
			mismatch("init_done", int'(init_done), int'(tbl_done[idx]));
		if (tbl_cmd[idx] == `SDRAM_CMD_MRS)
			mrs_cyc = cyc;
		last_cyc = cyc;
	endtask

	// skips nop cycles, anything else must be the next entry
	task automatic wait_command(input int idx);
		sample_cycle();
		while (pins == `SDRAM_CMD_NOP)
			sample_cycle();
		check_entry(idx);
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		cyc           = 0;
		last_cyc      = 0;
		last_prec_cyc = 0;
		mrs_cyc       = -1;
		done_seen     = 1'b0;
		fail_cnt      = 0;
		load_table();

		// reset and the first idle cycles after it
		repeat (10) begin
			sample_cycle();
			assert (pins == `SDRAM_CMD_NOP) else
				mismatch("command", int'(pins), int'(`SDRAM_CMD_NOP));
			assert (init_done == 1'b0) else mismatch("init_done", int'(init_done), 0);
		end

		for (int i = 0; i < NUM_ENTRIES; i++)
			wait_command(i);

		repeat (TAIL_CYCLES) begin
			sample_cycle();
			assert (pins == `SDRAM_CMD_NOP) else
				mismatch("command", int'(pins), int'(`SDRAM_CMD_NOP));
		end

		if (fail_cnt == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("=== FAIL ===");
			$fatal(1);
		end
	end

	// watchdog, init wait plus four refresh intervals and slack
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge S_CLK);
		report_fail($sformatf("timeout after %0d cycles, expected commands did not all appear",
			WATCHDOG_CYCLES));
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
hdl/sdram_pkg.sv
hdl/sdram_init.sv
hdl/sdram_aref.sv
hdl/sdram_arbiter.sv
hdl/sdram_ctrl_top.sv
bench/tb_clk_gen.sv
bench/tb_sdram_ctrl.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_sdram_ctrl
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
